// ==== verilog/afu_params.svh ====
// ======================================================================
// Shared sizes and constants of the host memory test block
// ======================================================================

`ifndef AFU_PARAMS_SVH
`define AFU_PARAMS_SVH

// Number of engines, one per host memory port
`define AFU_NUM_ENGINES 2

// CSR word address, low 3 bits pick the CSR and high bits pick the block
`define AFU_MMIO_ADDR_WIDTH 8

// Host memory line address width
`define AFU_MEM_ADDR_WIDTH 16

// Limit on reads in flight per engine
`define AFU_MAX_OUTSTANDING 8

// Test identifier, split into two 64-bit global CSRs
`define AFU_TEST_ID_LO 64'h5d2a_81c4_0f37_96be
`define AFU_TEST_ID_HI 64'h9e04_c7b1_3a68_d2f5

`endif

// ==== verilog/afu_pkg.sv ====
// ======================================================================
// Shared types and engine CSR index names of the host memory test block
// ======================================================================

`default_nettype none

`include "afu_params.svh"

package afu_pkg;

    // One CSR word, also the width of a host memory line
    typedef logic [63:0] t_csr_data;

    // Host memory line address
    typedef logic [`AFU_MEM_ADDR_WIDTH-1:0] t_mem_addr;

    // CSR index within a block of eight
    typedef logic [2:0] t_csr_idx;

    // Engine FSM states
    // Draining waits for the last read responses after issue is complete
    typedef enum logic [1:0]
    {
        ENG_IDLE     = 2'd0,
        ENG_WRITING  = 2'd1,
        ENG_READING  = 2'd2,
        ENG_DRAINING = 2'd3
    } t_eng_state;

    // Engine CSR indices, the same in every engine block
    localparam t_csr_idx CSR_BASE       = 3'd0;
    localparam t_csr_idx CSR_COUNT      = 3'd1;
    localparam t_csr_idx CSR_SEED       = 3'd2;
    localparam t_csr_idx CSR_CMD_STATUS = 3'd3;
    localparam t_csr_idx CSR_CHECKSUM   = 3'd4;
    localparam t_csr_idx CSR_RD_RESP    = 3'd5;
    localparam t_csr_idx CSR_WR_DONE    = 3'd6;
    localparam t_csr_idx CSR_INFO       = 3'd7;

endpackage

`default_nettype wire

// ==== verilog/csr_mgr.sv ====
// ======================================================================
// CSR manager decodes the CSR bus into global and per-engine CSR blocks
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

`include "afu_params.svh"

module csr_mgr
  #(
    parameter int NUM_ENGINES = `AFU_NUM_ENGINES
    )
   (
    input  logic clk,
    input  logic rst,

    // CSR bus, which never stalls
    input  logic mmio_write,
    input  logic mmio_read,
    input  logic [`AFU_MMIO_ADDR_WIDTH-1:0] mmio_address,
    input  afu_pkg::t_csr_data mmio_writedata,
    output logic mmio_readdatavalid,
    output afu_pkg::t_csr_data mmio_readdata,

    // Links to the engines
    output logic [NUM_ENGINES-1:0] eng_csr_write,
    output afu_pkg::t_csr_idx eng_csr_idx,
    output afu_pkg::t_csr_data eng_csr_wdata,
    input  logic [NUM_ENGINES*8*64-1:0] eng_csr_rdata
    );

    import afu_pkg::*;

    // Width of the block number in the upper address bits
    localparam int BLK_W = `AFU_MMIO_ADDR_WIDTH - 3;

    logic [BLK_W-1:0] blk;
    t_csr_idx idx;
    t_csr_data rd_data;


    // ====================================================================
    //
    //  Address decode
    //
    // ====================================================================

    // Block 0 is global and block e+1 belongs to engine e
    assign blk = mmio_address[`AFU_MMIO_ADDR_WIDTH-1:3];
    assign idx = mmio_address[2:0];

    // Index and data go to every engine, only the strobe is per engine
    assign eng_csr_idx = idx;
    assign eng_csr_wdata = mmio_writedata;

    // Write strobes are combinational so that an engine register
    // updates at the same edge where the bus write is sampled
    always_comb
    begin
        for (int e = 0; e < NUM_ENGINES; e = e + 1)
        begin
            eng_csr_write[e] = mmio_write && (blk == BLK_W'(e + 1));
        end
    end


    // ====================================================================
    //
    //  Read path
    //
    // ====================================================================

    // Select the word for the current read address
    // Unmapped blocks and unused global indices fall through as zero
    always_comb
    begin
        rd_data = '0;

        if (blk == '0)
        begin
            case (idx)
                // Test identifier, low half then high half
                3'd0: rd_data = `AFU_TEST_ID_LO;
                3'd1: rd_data = `AFU_TEST_ID_HI;
                // Engine count so that software can size its loops
                3'd2: rd_data = 64'(NUM_ENGINES);
                default: rd_data = '0;
            endcase
        end

        // Each engine exposes eight words packed in index order
        for (int e = 0; e < NUM_ENGINES; e = e + 1)
        begin
            if (blk == BLK_W'(e + 1))
            begin
                rd_data = eng_csr_rdata[(e * 8 + int'(idx)) * 64 +: 64];
            end
        end
    end

    // Response valid follows the read strobe by exactly one cycle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mmio_readdatavalid <= 1'b0;
        end
        else
        begin
            mmio_readdatavalid <= mmio_read;
        end
    end

    // Read data only needs to hold for the cycle where valid is high
    always_ff @(posedge clk)
    begin
        if (mmio_read)
        begin
            mmio_readdata <= rd_data;
        end
    end


    // ====================================================================
    //
    //  Checks
    //
    // ====================================================================

    // The bus shares one address between reads and writes, so the host
    // must never issue both in the same cycle
    assert property (@(posedge clk) disable iff (rst) !(mmio_read && mmio_write))
        else $error("CSR read and write strobes high in the same cycle");

endmodule

`default_nettype wire

// ==== verilog/host_mem_rdwr_engine.sv ====
// ======================================================================
// Host memory engine that writes a seeded pattern to a line range and
// reads it back with several reads in flight, summing the responses
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

`include "afu_params.svh"

module host_mem_rdwr_engine
  #(
    parameter int ENGINE_NUMBER = 0
    )
   (
    input  logic clk,
    input  logic rst,

    // CSR link from the manager, already decoded to this engine
    input  logic csr_write,
    input  afu_pkg::t_csr_idx csr_idx,
    input  afu_pkg::t_csr_data csr_wdata,
    output logic [8*64-1:0] csr_rdata,

    // Host memory port
    output logic mem_read,
    output logic mem_write,
    output afu_pkg::t_mem_addr mem_address,
    output afu_pkg::t_csr_data mem_writedata,
    input  logic mem_waitrequest,
    input  logic mem_readdatavalid,
    input  afu_pkg::t_csr_data mem_readdata
    );

    import afu_pkg::*;

    localparam int MAX_OUT = `AFU_MAX_OUTSTANDING;
    localparam int OUT_W = $clog2(MAX_OUT + 1);

    // Configuration set by software
    t_mem_addr base_addr;
    t_mem_addr line_count;
    t_csr_data seed;

    // FSM and pass progress
    t_eng_state state;
    logic run_rd_pass;
    t_mem_addr wr_cnt;
    t_mem_addr rd_issue_cnt;
    t_mem_addr rd_resp_cnt;
    logic [OUT_W-1:0] rd_in_flight;
    t_csr_data checksum;

    logic active;
    logic wr_accept;
    logic rd_accept;
    logic start_cmd;


    // ====================================================================
    //
    //  Request generation
    //
    // ====================================================================

    assign active = (state != ENG_IDLE);

    // Requests come straight from registers that only move on accept,
    // so a stalled request stays unchanged under waitrequest
    assign mem_write = (state == ENG_WRITING);
    assign mem_read = (state == ENG_READING) && (rd_in_flight < OUT_W'(MAX_OUT));
    assign mem_address = base_addr + ((state == ENG_WRITING) ? wr_cnt : rd_issue_cnt);
    assign mem_writedata = seed + 64'(wr_cnt);

    assign wr_accept = mem_write && !mem_waitrequest;
    assign rd_accept = mem_read && !mem_waitrequest;

    // A command with no run bit set, or one sent while busy, is dropped
    assign start_cmd = csr_write && (csr_idx == CSR_CMD_STATUS) && !active &&
                       (csr_wdata[1:0] != 2'b00);


    // ====================================================================
    //
    //  CSRs
    //
    // ====================================================================

    always_ff @(posedge clk)
    begin
        if (csr_write)
        begin
            case (csr_idx)
                CSR_BASE:  base_addr <= t_mem_addr'(csr_wdata);
                CSR_COUNT: line_count <= t_mem_addr'(csr_wdata);
                CSR_SEED:  seed <= csr_wdata;
                default: ;
            endcase
        end
    end

    // Status keeps active in bit 0 and the FSM state in bits 5:4
    always_comb
    begin
        csr_rdata[int'(CSR_BASE)*64 +: 64] = 64'(base_addr);
        csr_rdata[int'(CSR_COUNT)*64 +: 64] = 64'(line_count);
        csr_rdata[int'(CSR_SEED)*64 +: 64] = seed;
        csr_rdata[int'(CSR_CMD_STATUS)*64 +: 64] = {58'd0, state, 3'd0, active};
        csr_rdata[int'(CSR_CHECKSUM)*64 +: 64] = checksum;
        csr_rdata[int'(CSR_RD_RESP)*64 +: 64] = 64'(rd_resp_cnt);
        csr_rdata[int'(CSR_WR_DONE)*64 +: 64] = 64'(wr_cnt);
        csr_rdata[int'(CSR_INFO)*64 +: 64] = 64'(ENGINE_NUMBER);
    end


    // ====================================================================
    //
    //  Engine FSM and read accounting
    //
    // ====================================================================

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= ENG_IDLE;
            run_rd_pass <= 1'b0;
            wr_cnt <= '0;
            rd_issue_cnt <= '0;
            rd_resp_cnt <= '0;
            rd_in_flight <= '0;
            checksum <= '0;
        end
        else
        begin
            case (state)
                ENG_IDLE:
                begin
                    // Results clear even when the count is zero
                    if (start_cmd)
                    begin
                        wr_cnt <= '0;
                        rd_issue_cnt <= '0;
                        rd_resp_cnt <= '0;
                        checksum <= '0;
                        run_rd_pass <= csr_wdata[1];
                        // With both bits set the write pass goes first
                        if (line_count != '0)
                        begin
                            state <= csr_wdata[0] ? ENG_WRITING : ENG_READING;
                        end
                    end
                end
                ENG_WRITING:
                begin
                    if (wr_accept)
                    begin
                        wr_cnt <= wr_cnt + 1'b1;
                        if (wr_cnt == line_count - 1'b1)
                        begin
                            state <= run_rd_pass ? ENG_READING : ENG_IDLE;
                        end
                    end
                end
                ENG_READING:
                begin
                    if (rd_accept)
                    begin
                        rd_issue_cnt <= rd_issue_cnt + 1'b1;
                        if (rd_issue_cnt == line_count - 1'b1)
                        begin
                            state <= ENG_DRAINING;
                        end
                    end
                end
                default:
                begin
                    // All reads issued, wait for the last response
                    if (rd_resp_cnt == line_count)
                    begin
                        state <= ENG_IDLE;
                    end
                end
            endcase

            // Responses return in order and are always taken
            if (mem_readdatavalid)
            begin
                checksum <= checksum + mem_readdata;
                rd_resp_cnt <= rd_resp_cnt + 1'b1;
            end

            rd_in_flight <= rd_in_flight + OUT_W'(rd_accept) - OUT_W'(mem_readdatavalid);
        end
    end


    // ====================================================================
    //
    //  Checks
    //
    // ====================================================================

    assert property (@(posedge clk) disable iff (rst) rd_in_flight <= OUT_W'(MAX_OUT))
        else $error("Engine %0d has too many reads in flight", ENGINE_NUMBER);

    assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
        else $error("Engine %0d drove read and write together", ENGINE_NUMBER);

    // A stalled request must be presented again unchanged
    assert property (@(posedge clk) disable iff (rst)
                     (mem_read || mem_write) && mem_waitrequest |=>
                     $stable({mem_read, mem_write, mem_address, mem_writedata}))
        else $error("Engine %0d changed a stalled request", ENGINE_NUMBER);

endmodule

`default_nettype wire

// ==== verilog/afu.sv ====
// ======================================================================
// Host memory test block top with one CSR manager and an engine array
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

`include "afu_params.svh"

module afu
  #(
    parameter int NUM_ENGINES = `AFU_NUM_ENGINES
    )
   (
    input  logic clk,
    input  logic rst,

    // CSR bus from the host
    input  logic mmio_write,
    input  logic mmio_read,
    input  logic [`AFU_MMIO_ADDR_WIDTH-1:0] mmio_address,
    input  afu_pkg::t_csr_data mmio_writedata,
    output logic mmio_readdatavalid,
    output afu_pkg::t_csr_data mmio_readdata,

    // Host memory ports, one element per engine
    output logic [NUM_ENGINES-1:0] mem_read,
    output logic [NUM_ENGINES-1:0] mem_write,
    output afu_pkg::t_mem_addr [NUM_ENGINES-1:0] mem_address,
    output afu_pkg::t_csr_data [NUM_ENGINES-1:0] mem_writedata,
    input  logic [NUM_ENGINES-1:0] mem_waitrequest,
    input  logic [NUM_ENGINES-1:0] mem_readdatavalid,
    input  afu_pkg::t_csr_data [NUM_ENGINES-1:0] mem_readdata
    );

    import afu_pkg::*;

    // CSR links between the manager and the engines
    logic [NUM_ENGINES-1:0] eng_csr_write;
    t_csr_idx eng_csr_idx;
    t_csr_data eng_csr_wdata;
    logic [NUM_ENGINES*8*64-1:0] eng_csr_rdata;


    // ====================================================================
    //
    //  CSR manager
    //
    // ====================================================================

    csr_mgr
      #(
        .NUM_ENGINES(NUM_ENGINES)
        )
      csr_mgr
       (
        .clk,
        .rst,
        .mmio_write,
        .mmio_read,
        .mmio_address,
        .mmio_writedata,
        .mmio_readdatavalid,
        .mmio_readdata,
        .eng_csr_write,
        .eng_csr_idx,
        .eng_csr_wdata,
        .eng_csr_rdata
        );


    // ====================================================================
    //
    //  Engines, one per host memory port
    //
    // ====================================================================

    for (genvar e = 0; e < NUM_ENGINES; e = e + 1)
    begin : eng
        host_mem_rdwr_engine
          #(
            .ENGINE_NUMBER(e)
            )
          eng
           (
            .clk,
            .rst,
            .csr_write(eng_csr_write[e]),
            .csr_idx(eng_csr_idx),
            .csr_wdata(eng_csr_wdata),
            .csr_rdata(eng_csr_rdata[e*8*64 +: 8*64]),
            .mem_read(mem_read[e]),
            .mem_write(mem_write[e]),
            .mem_address(mem_address[e]),
            .mem_writedata(mem_writedata[e]),
            .mem_waitrequest(mem_waitrequest[e]),
            .mem_readdatavalid(mem_readdatavalid[e]),
            .mem_readdata(mem_readdata[e])
            );
    end

endmodule

`default_nettype wire

// ==== verification/host_mem_model.sv ====
// ======================================================================
// Behavioral host memory for one engine port, sparse line storage and
// a pipelined read path with a fixed latency of three cycles
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

`include "afu_params.svh"

module host_mem_model
   (
    input  logic clk,
    input  logic rst,
    input  logic read,
    input  logic write,
    input  afu_pkg::t_mem_addr address,
    input  afu_pkg::t_csr_data writedata,
    input  logic waitrequest,
    output logic readdatavalid,
    output afu_pkg::t_csr_data readdata
    );

    import afu_pkg::*;

    localparam int LATENCY = 3;

    // Only lines that were written exist in the array
    t_csr_data lines [t_mem_addr];

    // Read pipeline, stage 0 is loaded at the accepting clock edge
    logic [LATENCY-1:0] pipe_valid;
    t_csr_data pipe_data [LATENCY];

    // Response outputs start low so the DUT sees no response before reset
    logic rsp_valid = 1'b0;
    t_csr_data rsp_data = '0;

    assign readdatavalid = rsp_valid;
    assign readdata = rsp_data;

    // Unwritten lines return a pattern built from the whole address
    function automatic t_csr_data line_value(input t_mem_addr addr);
        if (lines.exists(addr))
            return lines[addr];
        else
            return {addr, ~addr, addr, ~addr};
    endfunction

    // Requests are taken only in cycles without waitrequest
    always @(posedge clk)
    begin
        if (!rst && write && !waitrequest)
        begin
            lines[address] = writedata;
        end

        if (rst)
            pipe_valid <= '0;
        else
            pipe_valid <= {pipe_valid[LATENCY-2:0], read && !waitrequest};

        pipe_data[0] <= line_value(address);
        for (int s = 1; s < LATENCY; s = s + 1)
        begin
            pipe_data[s] <= pipe_data[s-1];
        end
    end

    // Responses change on the falling edge like every other DUT input
    always @(negedge clk)
    begin
        if (rst)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= pipe_valid[LATENCY-1];
        rsp_data <= pipe_data[LATENCY-1];
    end

endmodule

`default_nettype wire

// ==== verification/afu_tb.sv ====
// ======================================================================
// Testbench for the host memory test block with CSR bus tasks, host
// memory models under random waitrequest and checks against a reference
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

`include "afu_params.svh"

module afu_tb;

    import afu_pkg::*;

    localparam int NUM_ENG = `AFU_NUM_ENGINES;
    localparam int AW = `AFU_MMIO_ADDR_WIDTH;
    localparam int POLL_LIMIT = 400;

    logic clk;
    logic rst;
    logic mmio_write;
    logic mmio_read;
    logic [AW-1:0] mmio_address;
    t_csr_data mmio_writedata;
    logic mmio_readdatavalid;
    t_csr_data mmio_readdata;

    logic [NUM_ENG-1:0] mem_read;
    logic [NUM_ENG-1:0] mem_write;
    logic [NUM_ENG-1:0] mem_waitrequest;
    logic [NUM_ENG-1:0] mem_readdatavalid;
    t_mem_addr [NUM_ENG-1:0] mem_address;
    t_csr_data [NUM_ENG-1:0] mem_writedata;
    t_csr_data [NUM_ENG-1:0] mem_readdata;

    logic [31:0] rnd_state;

    // Values waiting for the compare process in matching order
    t_csr_data got_q[$];
    t_csr_data want_q[$];
    string what_q[$];

    afu #(.NUM_ENGINES(NUM_ENG)) dut0
       (
        .clk,
        .rst,
        .mmio_write,
        .mmio_read,
        .mmio_address,
        .mmio_writedata,
        .mmio_readdatavalid,
        .mmio_readdata,
        .mem_read,
        .mem_write,
        .mem_address,
        .mem_writedata,
        .mem_waitrequest,
        .mem_readdatavalid,
        .mem_readdata
        );

    // One memory model per engine port
    for (genvar e = 0; e < NUM_ENG; e = e + 1)
    begin : mdl
        host_mem_model model
           (
            .clk,
            .rst,
            .read(mem_read[e]),
            .write(mem_write[e]),
            .address(mem_address[e]),
            .writedata(mem_writedata[e]),
            .waitrequest(mem_waitrequest[e]),
            .readdatavalid(mem_readdatavalid[e]),
            .readdata(mem_readdata[e])
            );
    end

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ====================================================================
    // Helpers and reference model
    // ====================================================================

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected checksum is the wrapping sum of seed plus i over the lines
    function automatic t_csr_data expected_checksum(input t_csr_data seed, input int count);
        t_csr_data sum;
        sum = '0;
        for (int i = 0; i < count; i = i + 1)
        begin
            sum = sum + seed + 64'(i);
        end
        return sum;
    endfunction

    function automatic logic [AW-1:0] eng_addr(input int eng, input t_csr_idx idx);
        return AW'((eng + 1) * 8) | AW'(idx);
    endfunction

    function automatic t_csr_data model_line(input int eng, input t_mem_addr addr);
        if (eng == 0)
            return mdl[0].model.line_value(addr);
        else
            return mdl[1].model.line_value(addr);
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "Run stopped");
    endtask

    task automatic queue_check(input string what, input t_csr_data got, input t_csr_data want);
        what_q.push_back(what);
        got_q.push_back(got);
        want_q.push_back(want);
    endtask

    task automatic csr_write(input logic [AW-1:0] addr, input t_csr_data data);
        @(negedge clk);
        mmio_write = 1'b1;
        mmio_address = addr;
        mmio_writedata = data;
        @(negedge clk);
        mmio_write = 1'b0;
    endtask

    // Response is due one cycle after the read strobe and lasts one cycle
    task automatic csr_read(input logic [AW-1:0] addr, output t_csr_data data);
        int n;
        n = 0;
        @(negedge clk);
        if (mmio_readdatavalid)
            stop_run($sformatf("CSR read valid high before the read of address %h", addr));
        mmio_read = 1'b1;
        mmio_address = addr;
        @(negedge clk);
        mmio_read = 1'b0;
        while (!mmio_readdatavalid && n < 4)
        begin
            @(negedge clk);
            n = n + 1;
        end
        if (!mmio_readdatavalid)
            stop_run($sformatf("CSR read of address %h got no response", addr));
        else if (n != 0)
            stop_run($sformatf("CSR read of address %h answered %0d cycles late", addr, n));
        else
            data = mmio_readdata;
    endtask

    task automatic expect_csr(input logic [AW-1:0] addr, input t_csr_data want,
                              input string what);
        t_csr_data got;
        csr_read(addr, got);
        queue_check(what, got, want);
    endtask

    task automatic configure(input int eng, input t_mem_addr base, input t_mem_addr count,
                             input t_csr_data seed);
        csr_write(eng_addr(eng, CSR_BASE), 64'(base));
        csr_write(eng_addr(eng, CSR_COUNT), 64'(count));
        csr_write(eng_addr(eng, CSR_SEED), seed);
    endtask

    task automatic wait_idle(input int eng);
        t_csr_data st;
        int n;
        n = 0;
        csr_read(eng_addr(eng, CSR_CMD_STATUS), st);
        while (st[0] && n < POLL_LIMIT)
        begin
            csr_read(eng_addr(eng, CSR_CMD_STATUS), st);
            n = n + 1;
        end
        if (st[0])
            stop_run($sformatf("Engine %0d still active after %0d status reads", eng, n));
    endtask

    task automatic check_results(input int eng, input int count, input t_csr_data seed,
                                 input int wr_lines);
        expect_csr(eng_addr(eng, CSR_WR_DONE), 64'(wr_lines),
                   $sformatf("engine %0d write count", eng));
        expect_csr(eng_addr(eng, CSR_RD_RESP), 64'(count),
                   $sformatf("engine %0d read responses", eng));
        expect_csr(eng_addr(eng, CSR_CHECKSUM), expected_checksum(seed, count),
                   $sformatf("engine %0d checksum", eng));
    endtask

    task automatic check_lines(input int eng, input t_mem_addr base, input int count,
                               input t_csr_data seed);
        t_mem_addr a;
        for (int i = 0; i < count; i = i + 1)
        begin
            a = base + t_mem_addr'(i);
            queue_check($sformatf("engine %0d line %h", eng, a), model_line(eng, a),
                        seed + 64'(i));
        end
    endtask

    // ====================================================================
    // Random waitrequest and compare process
    // ====================================================================

    // About one cycle in four stalls on each port
    initial
    begin
        mem_waitrequest = '0;
        rnd_state = 32'h3f34_262f;
        forever
        begin
            @(negedge clk);
            rnd_state = lcg_next(rnd_state);
            for (int e = 0; e < NUM_ENG; e = e + 1)
            begin
                mem_waitrequest[e] = (rnd_state[31 - 2 * e -: 2] == 2'b00);
            end
        end
    end

    always @(posedge clk)
    begin : compare
        t_csr_data got;
        t_csr_data want;
        string what;
        while (want_q.size() != 0)
        begin
            got = got_q.pop_front();
            want = want_q.pop_front();
            what = what_q.pop_front();
            assert (got === want)
            else
            begin
                $display("** Error at %0t: %s read %h, expected %h", $time, what, got, want);
                $display("Verification failed");
                $fatal(1, "Mismatch on %s", what);
            end
        end
    end

    // ====================================================================
    // Test sequence
    // ====================================================================

    initial
    begin
        t_csr_data seed_a;
        t_csr_data seed_b;
        int n;

        rst = 1'b1;
        mmio_write = 1'b0;
        mmio_read = 1'b0;
        mmio_address = '0;
        mmio_writedata = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Global block then unused indices and unmapped blocks
        expect_csr(AW'(0), `AFU_TEST_ID_LO, "test id low");
        expect_csr(AW'(1), `AFU_TEST_ID_HI, "test id high");
        expect_csr(AW'(2), 64'(NUM_ENG), "engine count");
        for (int i = 3; i < 8; i = i + 1)
        begin
            expect_csr(AW'(i), '0, $sformatf("unused global CSR %0d", i));
        end
        expect_csr(AW'((NUM_ENG + 1) * 8), '0, "first unmapped block");
        expect_csr({AW{1'b1}}, '0, "last unmapped block");

        // Configuration CSRs read back and each engine knows its index
        for (int e = 0; e < NUM_ENG; e = e + 1)
        begin
            configure(e, t_mem_addr'(32'h1000 * (e + 1) + e), t_mem_addr'(e + 3),
                      64'hc0de_0000_0000_0000 | 64'(e));
            expect_csr(eng_addr(e, CSR_BASE), 64'(32'h1000 * (e + 1) + e), "base");
            expect_csr(eng_addr(e, CSR_COUNT), 64'(e + 3), "count");
            expect_csr(eng_addr(e, CSR_SEED), 64'hc0de_0000_0000_0000 | 64'(e), "seed");
            expect_csr(eng_addr(e, CSR_INFO), 64'(e), "engine info");
        end

        // Write pass then read pass on engine 0
        seed_a = 64'h0123_4567_89ab_cdef;
        configure(0, 16'h0100, 16'd20, seed_a);
        csr_write(eng_addr(0, CSR_CMD_STATUS), 64'd3);
        wait_idle(0);
        check_results(0, 20, seed_a, 20);
        check_lines(0, 16'h0100, 20, seed_a);

        // Both engines at once while the engine 0 seed wraps during the pass
        seed_a = 64'hffff_ffff_ffff_fff0;
        seed_b = 64'h7a5c_3e19_0000_1000;
        configure(0, 16'h0400, 16'd37, seed_a);
        configure(1, 16'h2000, 16'd45, seed_b);
        csr_write(eng_addr(0, CSR_CMD_STATUS), 64'd3);
        csr_write(eng_addr(1, CSR_CMD_STATUS), 64'd3);
        wait_idle(0);
        wait_idle(1);
        check_results(0, 37, seed_a, 37);
        check_lines(0, 16'h0400, 37, seed_a);
        check_results(1, 45, seed_b, 45);
        check_lines(1, 16'h2000, 45, seed_b);

        // Zero count start stays idle and clears the checksum
        csr_write(eng_addr(1, CSR_COUNT), 64'd0);
        csr_write(eng_addr(1, CSR_CMD_STATUS), 64'd3);
        expect_csr(eng_addr(1, CSR_CMD_STATUS), '0, "status after zero count");
        expect_csr(eng_addr(1, CSR_CHECKSUM), '0, "checksum after zero count");

        // Read only pass over the lines written above
        csr_write(eng_addr(1, CSR_COUNT), 64'd45);
        csr_write(eng_addr(1, CSR_CMD_STATUS), 64'd2);
        wait_idle(1);
        check_results(1, 45, seed_b, 0);

        // Let the compare process empty its queue
        n = 0;
        while (want_q.size() != 0 && n < 20)
        begin
            @(negedge clk);
            n = n + 1;
        end
        if (want_q.size() == 0)
        begin
            $display("Verification passed");
            $finish;
        end
        else
        begin
            $display("Checks still pending at the end of the run");
            $display("Verification failed");
            $fatal(1, "Run stopped");
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verilog
verilog/afu_pkg.sv
verilog/csr_mgr.sv
verilog/host_mem_rdwr_engine.sv
verilog/afu.sv
verification/host_mem_model.sv
verification/afu_tb.sv

// ==== Makefile ====
# Verilator build and run of the host memory test block testbench

VERILATOR  ?= verilator
TOP        := afu_tb
LINT_TOP   := afu
FILELIST   := list.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The simulator exits with a failing status when the testbench stops on $fatal
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
